// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h1c00_0000

// architectural register count, r0 included
`define CORE_NUM_REGS 32

// pc step between sequential fetches
`define CORE_INST_BYTES 32'd4

// add.w major opcode, compared against inst[31:15]
`define CORE_OP_ADD_W 17'h00020

// addi.w major opcode, compared against inst[31:22]
`define CORE_OP_ADDI_W 10'h00a

// 3R format: rd in [4:0], rj in [9:5], rk in [14:10]
// 2RI12 format: rd in [4:0], rj in [9:5], si12 in [21:10]

`endif

// File: logic/core_pkg.sv
package core_pkg;

    // data word or byte address
    typedef logic [31:0] word_t;

    // raw instruction word as fetched
    typedef logic [31:0] inst_t;

    // register number, r0 to r31
    typedef logic [4:0] reg_idx_t;

    // fetch FSM
    // address phase drives AR, data phase waits for R
    typedef enum logic {
        FETCH_ADDR,
        FETCH_DATA
    } fetch_state_e;

endpackage

// File: logic/fetch_axi.sv
`timescale 1ns/100ps
`include "core_config.svh"

module fetch_axi (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // AXI4-Lite read address channel
    output core_pkg::word_t      araddr_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    // AXI4-Lite read data channel
    input  core_pkg::inst_t      rdata_i,
    input  logic [1:0]           rresp_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    // fetched word towards decode
    output logic                 if_valid_o,
    output core_pkg::inst_t      if_inst_o,
    output core_pkg::word_t      if_pc_o
);

    core_pkg::fetch_state_e state_q;
    core_pkg::word_t        pc_q;
    logic                   arvalid_q;
    logic                   rready_q;
    logic                   ar_done;
    logic                   r_done;

    // handshakes complete on an edge with valid and ready both high
    assign ar_done = arvalid_q & arready_i;
    assign r_done  = rvalid_i & rready_q;

    // address held from pc until the AR handshake
    assign araddr_o  = pc_q;
    assign arvalid_o = arvalid_q;
    assign rready_o  = rready_q;

    // only one read in flight, so the FSM alternates between phases
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= core_pkg::FETCH_ADDR;
            pc_q       <= `CORE_RESET_PC;
            arvalid_q  <= 1'b0;
            rready_q   <= 1'b0;
            if_valid_o <= 1'b0;
        end else begin
            // one cycle pulse per returned word
            if_valid_o <= r_done;
            case (state_q)
                core_pkg::FETCH_ADDR: begin
                    if (ar_done) begin
                        arvalid_q <= 1'b0;
                        rready_q  <= 1'b1;
                        state_q   <= core_pkg::FETCH_DATA;
                    end else begin
                        // raised first cycle after reset, then held until accepted
                        arvalid_q <= 1'b1;
                    end
                end
                core_pkg::FETCH_DATA: begin
                    if (r_done) begin
                        rready_q  <= 1'b0;
                        arvalid_q <= 1'b1;
                        pc_q      <= pc_q + `CORE_INST_BYTES;
                        state_q   <= core_pkg::FETCH_ADDR;
                    end
                end
                default: state_q <= core_pkg::FETCH_ADDR;
            endcase
        end
    end

    // word and its pc captured together, rresp_i is taken as is
    always_ff @(posedge clk) begin
        if (r_done) begin
            if_inst_o <= rdata_i;
            if_pc_o   <= pc_q;
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/100ps
`include "core_config.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // from fetch
    input  logic                 if_valid_i,
    input  core_pkg::inst_t      if_inst_i,
    input  core_pkg::word_t      if_pc_i,
    // register file read ports
    output core_pkg::reg_idx_t   rf_raddr1_o,
    output core_pkg::reg_idx_t   rf_raddr2_o,
    input  core_pkg::word_t      rf_rdata1_i,
    input  core_pkg::word_t      rf_rdata2_i,
    // bypass from the execute slot
    input  logic                 ex_fwd_we_i,
    input  core_pkg::reg_idx_t   ex_fwd_rd_i,
    input  core_pkg::word_t      ex_fwd_data_i,
    // bypass from the writeback register
    input  logic                 wb_we_i,
    input  core_pkg::reg_idx_t   wb_rd_i,
    input  core_pkg::word_t      wb_data_i,
    // execute slot
    output logic                 id_valid_o,
    output core_pkg::word_t      id_pc_o,
    output core_pkg::reg_idx_t   id_rd_o,
    output logic                 id_we_o,
    output core_pkg::word_t      id_src1_o,
    output core_pkg::word_t      id_src2_o
);

    core_pkg::reg_idx_t rd;
    core_pkg::word_t    imm;
    core_pkg::word_t    src1_byp;
    core_pkg::word_t    src2_byp;
    logic               is_add;
    logic               is_addi;

    // youngest producer wins, r0 is always zero
    function automatic core_pkg::word_t bypass_sel(
        input core_pkg::reg_idx_t idx,
        input core_pkg::word_t    rf_val
    );
        core_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_fwd_we_i && (ex_fwd_rd_i == idx)) begin
            val = ex_fwd_data_i;
        end else if (wb_we_i && (wb_rd_i == idx)) begin
            val = wb_data_i;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    // field split
    assign rd          = if_inst_i[4:0];
    assign rf_raddr1_o = if_inst_i[9:5];
    assign rf_raddr2_o = if_inst_i[14:10];
    assign is_add      = (if_inst_i[31:15] == `CORE_OP_ADD_W);
    assign is_addi     = (if_inst_i[31:22] == `CORE_OP_ADDI_W);
    // si12 sign extended
    assign imm         = {{20{if_inst_i[21]}}, if_inst_i[21:10]};

    always_comb begin
        src1_byp = bypass_sel(rf_raddr1_o, rf_rdata1_i);
        src2_byp = bypass_sel(rf_raddr2_o, rf_rdata2_i);
    end

    // unknown encodings and writes to r0 retire without a write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o <= 1'b0;
            id_we_o    <= 1'b0;
        end else begin
            id_valid_o <= if_valid_i;
            id_we_o    <= if_valid_i & (is_add | is_addi) & (rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid_i) begin
            id_pc_o   <= if_pc_i;
            id_rd_o   <= rd;
            id_src1_o <= src1_byp;
            // immediate replaces rk for addi.w
            id_src2_o <= is_addi ? imm : src2_byp;
        end
    end

endmodule

// File: logic/exec_wb_stage.sv
`timescale 1ns/100ps

module exec_wb_stage (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // from decode
    input  logic                 id_valid_i,
    input  core_pkg::word_t      id_pc_i,
    input  core_pkg::reg_idx_t   id_rd_i,
    input  logic                 id_we_i,
    input  core_pkg::word_t      id_src1_i,
    input  core_pkg::word_t      id_src2_i,
    // execute slot bypass
    output logic                 ex_fwd_we_o,
    output core_pkg::reg_idx_t   ex_fwd_rd_o,
    output core_pkg::word_t      ex_fwd_data_o,
    // writeback register, feeds regfile and debug port
    output logic                 wb_we_o,
    output core_pkg::reg_idx_t   wb_rd_o,
    output core_pkg::word_t      wb_data_o,
    output core_pkg::word_t      wb_pc_o
);

    logic               ex_valid_q;
    logic               ex_we_q;
    core_pkg::word_t    ex_pc_q;
    core_pkg::reg_idx_t ex_rd_q;
    core_pkg::word_t    ex_src1_q;
    core_pkg::word_t    ex_src2_q;
    core_pkg::word_t    ex_sum;

    // add.w and addi.w share the adder, 32-bit wraparound
    assign ex_sum = ex_src1_q + ex_src2_q;

    assign ex_fwd_we_o   = ex_we_q;
    assign ex_fwd_rd_o   = ex_rd_q;
    assign ex_fwd_data_o = ex_sum;

    // bubbles never write
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_q <= 1'b0;
            ex_we_q    <= 1'b0;
            wb_we_o    <= 1'b0;
        end else begin
            ex_valid_q <= id_valid_i;
            ex_we_q    <= id_valid_i & id_we_i;
            wb_we_o    <= ex_we_q;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid_i) begin
            ex_pc_q   <= id_pc_i;
            ex_rd_q   <= id_rd_i;
            ex_src1_q <= id_src1_i;
            ex_src2_q <= id_src2_i;
        end
        // pc tracks every retiring instruction, no-ops too
        if (ex_valid_q) begin
            wb_pc_o   <= ex_pc_q;
            wb_rd_o   <= ex_rd_q;
            wb_data_o <= ex_sum;
        end
    end

endmodule

// File: logic/regfile.sv
`timescale 1ns/100ps
`include "core_config.svh"

module regfile (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  core_pkg::reg_idx_t   raddr1_i,
    input  core_pkg::reg_idx_t   raddr2_i,
    output core_pkg::word_t      rdata1_o,
    output core_pkg::word_t      rdata2_o,
    input  logic                 we_i,
    input  core_pkg::reg_idx_t   waddr_i,
    input  core_pkg::word_t      wdata_i
);

    core_pkg::word_t regs_q [`CORE_NUM_REGS];

    // asynchronous read, r0 forced to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

    // write lands at the edge, entry 0 is never written
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: logic/core_top.sv
`timescale 1ns/100ps

module core_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // AXI4-Lite read channel
    output core_pkg::word_t      araddr_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  core_pkg::inst_t      rdata_i,
    input  logic [1:0]           rresp_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    // writeback debug port
    output core_pkg::word_t      debug_wb_pc_o,
    output logic                 debug_wb_rf_we_o,
    output core_pkg::reg_idx_t   debug_wb_rf_wnum_o,
    output core_pkg::word_t      debug_wb_rf_wdata_o
);

    // fetch to decode
    logic               if_valid;
    core_pkg::inst_t    if_inst;
    core_pkg::word_t    if_pc;

    // decode to execute
    logic               id_valid;
    core_pkg::word_t    id_pc;
    core_pkg::reg_idx_t id_rd;
    logic               id_we;
    core_pkg::word_t    id_src1;
    core_pkg::word_t    id_src2;

    // register file reads
    core_pkg::reg_idx_t rf_raddr1;
    core_pkg::reg_idx_t rf_raddr2;
    core_pkg::word_t    rf_rdata1;
    core_pkg::word_t    rf_rdata2;

    // bypass and writeback
    logic               ex_fwd_we;
    core_pkg::reg_idx_t ex_fwd_rd;
    core_pkg::word_t    ex_fwd_data;
    logic               wb_we;
    core_pkg::reg_idx_t wb_rd;
    core_pkg::word_t    wb_data;
    core_pkg::word_t    wb_pc;

    fetch_axi i_fetch_axi (
        .clk        (clk),        .arst_n_i   (arst_n_i),
        .araddr_o   (araddr_o),   .arvalid_o  (arvalid_o),  .arready_i (arready_i),
        .rdata_i    (rdata_i),    .rresp_i    (rresp_i),    .rvalid_i  (rvalid_i),
        .rready_o   (rready_o),   .if_valid_o (if_valid),   .if_inst_o (if_inst),
        .if_pc_o    (if_pc)
    );

    decode_stage i_decode_stage (
        .clk           (clk),         .arst_n_i      (arst_n_i),
        .if_valid_i    (if_valid),    .if_inst_i     (if_inst),    .if_pc_i    (if_pc),
        .rf_raddr1_o   (rf_raddr1),   .rf_raddr2_o   (rf_raddr2),
        .rf_rdata1_i   (rf_rdata1),   .rf_rdata2_i   (rf_rdata2),
        .ex_fwd_we_i   (ex_fwd_we),   .ex_fwd_rd_i   (ex_fwd_rd),  .ex_fwd_data_i (ex_fwd_data),
        .wb_we_i       (wb_we),       .wb_rd_i       (wb_rd),      .wb_data_i  (wb_data),
        .id_valid_o    (id_valid),    .id_pc_o       (id_pc),      .id_rd_o    (id_rd),
        .id_we_o       (id_we),       .id_src1_o     (id_src1),    .id_src2_o  (id_src2)
    );

    exec_wb_stage i_exec_wb_stage (
        .clk           (clk),         .arst_n_i      (arst_n_i),
        .id_valid_i    (id_valid),    .id_pc_i       (id_pc),      .id_rd_i    (id_rd),
        .id_we_i       (id_we),       .id_src1_i     (id_src1),    .id_src2_i  (id_src2),
        .ex_fwd_we_o   (ex_fwd_we),   .ex_fwd_rd_o   (ex_fwd_rd),  .ex_fwd_data_o (ex_fwd_data),
        .wb_we_o       (wb_we),       .wb_rd_o       (wb_rd),      .wb_data_o  (wb_data),
        .wb_pc_o       (wb_pc)
    );

    regfile i_regfile (
        .clk      (clk),       .arst_n_i (arst_n_i),
        .raddr1_i (rf_raddr1), .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1), .rdata2_o (rf_rdata2),
        .we_i     (wb_we),     .waddr_i  (wb_rd),     .wdata_i  (wb_data)
    );

    // debug port is the writeback register itself
    assign debug_wb_pc_o       = wb_pc;
    assign debug_wb_rf_we_o    = wb_we;
    assign debug_wb_rf_wnum_o  = wb_rd;
    assign debug_wb_rf_wdata_o = wb_data;

endmodule

// File: bench/core_sva.sv
`timescale 1ns/100ps

module core_sva (
    input logic                   clk,
    input logic                   arst_n_i,
    input core_pkg::word_t        araddr_o,
    input logic                   arvalid_o,
    input logic                   arready_i,
    input logic                   rvalid_i,
    input logic                   rready_o,
    input core_pkg::fetch_state_e fetch_state_i,
    input core_pkg::word_t        debug_wb_pc_o
);

    // AR request held steady until accepted
    property ar_held_p;
        @(posedge clk) disable iff (!arst_n_i)
        (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o));
    endproperty

    // data phase only
    property rready_phase_p;
        @(posedge clk) disable iff (!arst_n_i)
        rready_o |-> (fetch_state_i != core_pkg::FETCH_ADDR);
    endproperty

    // if, id, ex, wb: pc of the fetched word on the debug port after 3 more edges
    property retire_latency_p;
        @(posedge clk) disable iff (!arst_n_i)
        (rvalid_i && rready_o) |-> ##4 (debug_wb_pc_o == $past(araddr_o, 4));
    endproperty

    assert property (ar_held_p)
        else $error("arvalid_o or araddr_o changed before arready_i");
    assert property (rready_phase_p)
        else $error("rready_o high while fetch is in its address phase");
    assert property (retire_latency_p)
        else $error("debug pc does not follow the R handshake by 3 cycles");

endmodule

bind core_top core_sva i_core_sva (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .arready_i     (arready_i),
    .rvalid_i      (rvalid_i),
    .rready_o      (rready_o),
    .fetch_state_i (i_fetch_axi.state_q),
    .debug_wb_pc_o (debug_wb_pc_o)
);

// File: bench/core_tb.sv
`timescale 1ns/100ps
`include "core_config.svh"

module core_tb;

    localparam int PROG_LEN    = 64;
    localparam int NUM_DLY     = 128;
    localparam int CYCLE_LIMIT = PROG_LEN * 12 + 200;

    logic               clk;
    logic               arst_n_i;
    logic               arready_i;
    logic               rvalid_i;
    logic [1:0]         rresp_i;
    core_pkg::inst_t    rdata_i;
    core_pkg::word_t    araddr_o;
    logic               arvalid_o;
    logic               rready_o;
    core_pkg::word_t    debug_wb_pc_o;
    logic               debug_wb_rf_we_o;
    core_pkg::reg_idx_t debug_wb_rf_wnum_o;
    core_pkg::word_t    debug_wb_rf_wdata_o;

    // program image and model state
    core_pkg::inst_t    prog [PROG_LEN];
    core_pkg::word_t    model_regs [`CORE_NUM_REGS];
    core_pkg::word_t    exp_pc [$];
    core_pkg::reg_idx_t exp_rd [$];
    core_pkg::word_t    exp_val [$];
    // memory model state
    int unsigned        ar_dly [NUM_DLY];
    int unsigned        r_dly [NUM_DLY];
    int unsigned        ar_wait = 0;
    int unsigned        r_wait = 0;
    int unsigned        n_rd = 0;
    logic               rd_busy = 1'b0;
    core_pkg::word_t    rd_addr;
    core_pkg::word_t    exp_addr = `CORE_RESET_PC;
    int                 cycles = 0;

    core_top i_core_top (
        .clk                 (clk),
        .arst_n_i            (arst_n_i),
        .araddr_o            (araddr_o),
        .arvalid_o           (arvalid_o),
        .arready_i           (arready_i),
        .rdata_i             (rdata_i),
        .rresp_i             (rresp_i),
        .rvalid_i            (rvalid_i),
        .rready_o            (rready_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_we_o    (debug_wb_rf_we_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    // 3R format, rk rj rd
    function automatic core_pkg::inst_t enc_add(input int rd, input int rj, input int rk);
        return {`CORE_OP_ADD_W, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    // 2RI12 format, si12 rj rd
    function automatic core_pkg::inst_t enc_addi(input int rd, input int rj, input int imm);
        return {`CORE_OP_ADDI_W, 12'(imm), 5'(rj), 5'(rd)};
    endfunction

    // one ISA step on the model registers, 1 when the instruction writes
    function automatic bit model_step(input core_pkg::inst_t inst,
                                      output core_pkg::reg_idx_t rd,
                                      output core_pkg::word_t val);
        core_pkg::word_t a;
        core_pkg::word_t b;
        rd  = inst[4:0];
        val = '0;
        a   = model_regs[inst[9:5]];
        b   = model_regs[inst[14:10]];
        if (inst[31:22] == `CORE_OP_ADDI_W) begin
            b = {{20{inst[21]}}, inst[21:10]};
        end else if (inst[31:15] != `CORE_OP_ADD_W) begin
            return 1'b0;
        end
        val = a + b;
        // r0 stays zero, the write is dropped
        if (rd == '0) begin
            return 1'b0;
        end
        model_regs[rd] = val;
        return 1'b1;
    endfunction

    // past the end of the image the top six bits are set
    // so neither opcode can match
    // low bits fold in the whole address
    function automatic core_pkg::inst_t mem_word(input core_pkg::word_t addr);
        core_pkg::word_t idx;
        core_pkg::inst_t word;
        idx = (addr - `CORE_RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            word = prog[idx];
        end else begin
            word = {6'h3f, addr[25:0] ^ {20'b0, addr[31:26]}};
        end
        return word;
    endfunction

    task automatic check_value(input string what, input core_pkg::word_t got,
                               input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR: %0d ns: %s is %h, expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        core_pkg::reg_idx_t rd;
        core_pkg::word_t    val;
        void'($urandom(26));
        arst_n_i  = 1'b0;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rresp_i   = 2'b00;
        rdata_i   = '0;
        // addi chains, dependent adds at distance 1 to 3, wraparound
        prog[0]  = enc_addi(1, 0, 5);
        prog[1]  = enc_addi(2, 1, -7);
        prog[2]  = enc_addi(3, 2, 2047);
        prog[3]  = enc_add(4, 1, 2);
        prog[4]  = enc_add(5, 4, 3);
        prog[5]  = enc_add(6, 5, 4);
        prog[6]  = enc_addi(7, 0, -1);
        prog[7]  = enc_addi(7, 7, 1);
        // r0 targets, an unknown word, then r0 as a source
        prog[8]  = enc_addi(0, 1, 3);
        prog[9]  = enc_add(0, 5, 6);
        prog[10] = 32'hdead_beef;
        prog[11] = enc_add(9, 0, 1);
        prog[12] = enc_addi(10, 0, -2048);
        prog[13] = enc_add(10, 10, 10);
        // random tail over r0..r7 keeps dependencies dense
        for (int i = 14; i < PROG_LEN; i++) begin
            case ($urandom_range(3, 0))
                0:       prog[i] = $urandom() | 32'hfc00_0000;
                1:       prog[i] = enc_add($urandom_range(7, 0), $urandom_range(7, 0),
                                           $urandom_range(7, 0));
                default: prog[i] = enc_addi($urandom_range(7, 0), $urandom_range(7, 0),
                                            $urandom_range(4095, 0));
            endcase
        end
        for (int i = 0; i < NUM_DLY; i++) begin
            ar_dly[i] = $urandom_range(3, 0);
            r_dly[i]  = $urandom_range(3, 0);
        end
        ar_wait = ar_dly[0];
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (model_step(prog[i], rd, val)) begin
                exp_pc.push_back(`CORE_RESET_PC + i * `CORE_INST_BYTES);
                exp_rd.push_back(rd);
                exp_val.push_back(val);
            end
        end
        repeat (8) @(negedge clk);
        check_value("arvalid_o in reset", arvalid_o, '0);
        check_value("rready_o in reset", rready_o, '0);
        check_value("debug_wb_rf_we_o in reset", debug_wb_rf_we_o, '0);
        arst_n_i = 1'b1;
        while (exp_pc.size() != 0) begin
            @(negedge clk);
        end
        // tail of unknown words must stay silent
        repeat (40) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

    // AXI4-Lite read slave, R handled before AR so data never leads its address
    always @(negedge clk) begin
        if (arst_n_i) begin
            rvalid_i = 1'b0;
            if (rd_busy) begin
                if (r_wait > 0) begin
                    r_wait--;
                end else begin
                    rvalid_i = 1'b1;
                    rdata_i  = mem_word(rd_addr);
                    rd_busy  = !rready_o;
                end
            end
            arready_i = 1'b0;
            if (arvalid_o) begin
                if (ar_wait > 0) begin
                    ar_wait--;
                end else begin
                    arready_i = 1'b1;
                    check_value("araddr_o", araddr_o, exp_addr);
                    rd_addr  = araddr_o;
                    rd_busy  = 1'b1;
                    exp_addr = exp_addr + `CORE_INST_BYTES;
                    r_wait   = r_dly[n_rd % NUM_DLY];
                    n_rd++;
                    ar_wait  = ar_dly[n_rd % NUM_DLY];
                end
            end
        end
    end

    // retired writes against the model, in program order
    always @(negedge clk) begin
        if (arst_n_i && debug_wb_rf_we_o) begin
            if (exp_pc.size() == 0) begin
                $display("register r%0d written by pc %h with no write left to expect",
                         debug_wb_rf_wnum_o, debug_wb_pc_o);
                $display("*** FAILED ***");
                $fatal(1, "extra register write at %0d ns", $time);
            end else begin
                check_value("debug_wb_pc_o", debug_wb_pc_o, exp_pc.pop_front());
                check_value("debug_wb_rf_wnum_o", debug_wb_rf_wnum_o, exp_rd.pop_front());
                check_value("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o, exp_val.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("*** FAILED ***");
            $fatal(1, "timeout after %0d cycles with %0d writes still missing",
                   cycles, exp_pc.size());
        end
    end

endmodule

// File: vlog.f
+incdir+logic
logic/core_pkg.sv
logic/fetch_axi.sv
logic/decode_stage.sv
logic/exec_wb_stage.sv
logic/regfile.sv
logic/core_top.sv
bench/core_sva.sv
bench/core_tb.sv

// File: Bender.yml
package:
  name: core_lite

export_include_dirs:
  - logic

sources:
  - files:
      - logic/core_pkg.sv
      - logic/fetch_axi.sv
      - logic/decode_stage.sv
      - logic/exec_wb_stage.sv
      - logic/regfile.sv
      - logic/core_top.sv
  - target: test
    files:
      - bench/core_sva.sv
      - bench/core_tb.sv
